//--- cpc_support.f
source/cpc_support_pkg.sv
source/boot_loader.sv
source/sdram_request_mux.sv
source/mf2_control.sv
source/mf2_shadow_map.sv
source/mf2_ram.sv
source/cpc_support.sv
bench/cpc_support_assert.sv
bench/cpc_support_tb.sv

//--- bench/cpc_support_tb.sv
// CPC support testbench with clock, reset, seeded stimulus, reference model and compare tasks
`timescale 1ns/100ps
`default_nettype none

module cpc_support_tb import cpc_support_pkg::*; ();

	localparam int RESET_CYCLES   = 16;
	localparam int ROM_BYTES      = 30;
	localparam int EXT_FILES      = 6;
	localparam int EXT_BYTES      = 4;
	localparam int CTRL_STEPS     = 30;
	localparam int SHADOW_WRITES  = 30;
	localparam int CPU_STEPS      = 40;
	localparam int PHASE_CYCLES   = RESET_CYCLES + ROM_BYTES * 2 + 4
		+ EXT_FILES * (3 + EXT_BYTES * 2) + 12 + 3 * (3 + CTRL_STEPS * 2)
		+ 4 + (SHADOW_WRITES + 11) * 2 + (SHADOW_WRITES + 10) * 3 + CPU_STEPS + 4;
	localparam int TIMEOUT_CYCLES = 2 * PHASE_CYCLES;

	logic         clk_sys = 1'b0;
	logic         reset;
	dl_bus_t      dl;
	cpu_bus_t     cpu;
	logic         key_nmi;
	logic         cfg_cpc664;
	mf2_mode_t    cfg_mf2;
	mem_req_t     mem_req;
	logic [255:0] rom_map;
	logic         model;
	logic [7:0]   mf2_dout;
	logic         nmi;
	logic         mf2_active;

	// Reference model state
	logic [255:0] m_map;
	logic [8:0]   m_page;
	logic         m_combo;
	logic         m_model;
	logic         m_nmi, m_en, m_hidden;
	logic         m_old_key, m_old_m1, m_old_io, m_old_wr, m_old_dl;
	logic [4:0]   m_pen;
	logic [3:0]   m_crtc;
	logic [7:0]   m_ram [8192];
	logic [12:0]  shadow_q [$];

	int err_req, err_map, err_byte, err_bit;
	int cycles;

	cpc_support cpc_support_inst (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.dl         (dl),
		.cpu        (cpu),
		.key_nmi    (key_nmi),
		.cfg_cpc664 (cfg_cpc664),
		.cfg_mf2    (cfg_mf2),
		.mem_req    (mem_req),
		.rom_map    (rom_map),
		.model      (model),
		.mf2_dout   (mf2_dout),
		.nmi        (nmi),
		.mf2_active (mf2_active)
	);

	always #50 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout, the run took more than %0d clock cycles", TIMEOUT_CYCLES);
			$display("Regression failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Compare tasks
	task automatic check_req(input string name, input mem_req_t got, input mem_req_t exp);
		if (got !== exp) begin
			$display("Fail %s got %h expected %h", name, got, exp);
			err_req++;
		end
	endtask

	task automatic check_map(input string name, input logic [255:0] got, input logic [255:0] exp);
		if (got !== exp) begin
			$display("Fail %s got %h expected %h", name, got, exp);
			err_map++;
		end
	endtask

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			$display("Fail %s got %h expected %h", name, got, exp);
			err_byte++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Fail %s got %h expected %h", name, got, exp);
			err_bit++;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Reference rules
	function automatic logic [3:0] hex_nibble(input logic [7:0] c);
		if (c >= "0" && c <= "9") return 4'(c - "0");
		if (c >= "A" && c <= "F") return 4'(c - "A" + 10);
		return 4'hE;    // Bad character
	endfunction

	function automatic logic [8:0] ext_page_of(input logic [15:0] e);
		if (e == "ZZ" || e == "Z0") return 9'h000;
		return {1'b1, hex_nibble(e[15:8]), hex_nibble(e[7:0])};
	endfunction

	function automatic logic load_ok(input dl_bus_t d);
		return (d.index == DL_IDX_EXT) || (d.addr[24:14] < 11'd8);
	endfunction

	function automatic mem_req_t expect_load(input dl_bus_t d, input logic [8:0] pg,
		input logic mdl);
		mem_req_t r;
		logic [8:0] p;
		r.oe = 1'b0;
		r.we = d.wr & load_ok(d);
		r.din = d.data;
		if (d.index == DL_IDX_EXT) begin
			p = {pg[8], pg[7:0] + d.addr[21:14]};
			r.bank = {1'b0, mdl};
		end else begin
			case (d.addr[15:14])
				2'd0: p = PAGE_OS;
				2'd1: p = PAGE_BASIC;
				2'd2: p = PAGE_AMSDOS;
				default: p = PAGE_MF2;
			endcase
			r.bank = {1'b0, d.addr[16]};
		end
		r.addr.flat = {p, d.addr[13:0]};
		return r;
	endfunction

	function automatic mem_req_t expect_cpu(input cpu_bus_t c, input logic en, input logic mdl);
		mem_req_t r;
		logic rom_w;
		logic ram_w;
		rom_w = en && c.addr[15:13] == 3'b000;
		ram_w = en && c.addr[15:13] == 3'b001;
		r.oe = c.mem_rd & ~ram_w;
		r.we = c.mem_wr & ~rom_w & ~ram_w;
		r.bank = {1'b0, mdl};
		r.din = c.dout;
		r.addr.flat = rom_w ? {PAGE_MF2, c.addr[13:0]} : c.ram_a;
		return r;
	endfunction

	// Valid bit above the shadow address
	function automatic logic [13:0] shadow_of(input logic [7:0] hi, input logic [7:0] v);
		case (hi)
			PORT_GA:
				case (v[7:6])
					2'b00: return {1'b1, SHADOW_PEN};
					2'b01: return m_pen[4] ? {1'b1, SHADOW_BORDER} :
						{1'b1, SHADOW_PEN_BASE, m_pen[3:0]};
					2'b10: return {1'b1, SHADOW_MODE};
					default: return {1'b1, SHADOW_BANK};
				endcase
			PORT_CRTC_SEL: return {1'b1, SHADOW_CRTC_SEL};
			PORT_CRTC_DATA: return {1'b1, SHADOW_CRTC_BASE, m_crtc};
			PORT_PPI: return {1'b1, SHADOW_PPI};
			PORT_ROM_SEL: return {1'b1, SHADOW_ROM_SEL};
			default: return 14'h0;
		endcase
	endfunction

	//////////////////////////////////////////////////////////////////////
	// One clock of model update from the held inputs, then drive after the edge
	task automatic tick;
		logic [13:0] sh;
		logic        n_nmi, n_en, n_hid;
		mem_req_t    e;
		sh = (cpu.io_wr && !m_old_io) ? shadow_of(cpu.addr[15:8], cpu.dout) : 14'h0;
		if (sh[13])
			m_ram[sh[12:0]] = cpu.dout;
		else if (cpu.mem_wr && m_en && cpu.addr[15:13] == 3'b001)
			m_ram[cpu.ram_a[12:0]] = cpu.dout;
		n_nmi = m_nmi;
		n_en  = m_en;
		n_hid = m_hidden;
		e = expect_load(dl, m_page, m_model);
		if (reset) begin
			n_nmi = 1'b0;
			n_en  = 1'b0;
			n_hid = (cfg_mf2 != MF2_ENABLED);
			m_pen = '0;
			m_crtc = '0;
			m_map = '0;
			m_page = '0;
			m_combo = 1'b0;
			m_model = cfg_cpc664;
		end else begin
			if (key_nmi && !m_old_key && !m_en && cfg_mf2 != MF2_DISABLED) n_nmi = 1'b1;
			if (m_nmi && cpu.m1 && !m_old_m1 && cpu.addr == MF2_NMI_VECTOR) begin
				n_nmi = 1'b0;
				n_en  = 1'b1;
				n_hid = 1'b0;
			end
			if (m_en && cpu.m1 && !m_old_m1 && cpu.addr == MF2_HIDE_ADDR) n_hid = 1'b1;
			if (cpu.io_wr && !m_old_io && cpu.addr[15:2] == MF2_PAGE_PORT)
				n_en = !cpu.addr[1] && !m_hidden && cfg_mf2 != MF2_DISABLED;
			if (sh[13] && cpu.addr[15:8] == PORT_GA && cpu.dout[7:6] == 2'b00) m_pen = cpu.dout[4:0];
			if (sh[13] && cpu.addr[15:8] == PORT_CRTC_SEL) m_crtc = cpu.dout[3:0];
			// Download strobe falling edge
			if (dl.download && (dl.index == DL_IDX_ROM || dl.index == DL_IDX_EXT)
				&& m_old_wr && !dl.wr && load_ok(dl)) begin
				if (e.addr.rom.hi) m_map[e.addr.rom.page] = 1'b1;
				if (m_combo && &e.addr.rom.offset) begin
					m_combo = 1'b0;
					m_page = PAGE_COMBO_END;
				end
			end
			if (dl.download && dl.index == DL_IDX_EXT && !m_old_dl) begin
				m_page = ext_page_of(dl.ext);
				m_combo = (dl.ext == "Z0");
			end
		end
		m_nmi = n_nmi;
		m_en = n_en;
		m_hidden = n_hid;
		m_old_key = key_nmi;
		m_old_m1 = cpu.m1;
		m_old_io = cpu.io_wr;
		m_old_wr = dl.wr;
		m_old_dl = dl.download;
		@(posedge clk_sys);
		#10;
	endtask

	task automatic apply_reset(input int n);
		reset = 1'b1;
		repeat (n) tick();
		reset = 1'b0;
	endtask

	task automatic io_write(input logic [15:0] a, input logic [7:0] v);
		cpu.addr = a;
		cpu.dout = v;
		cpu.io_wr = 1'b1;
		tick();
		cpu.io_wr = 1'b0;
		tick();
	endtask

	task automatic fetch(input logic [15:0] a);
		cpu.addr = a;
		cpu.m1 = 1'b1;
		tick();
		cpu.m1 = 1'b0;
		tick();
	endtask

	// Download one byte, check the request, then drop the strobe
	task automatic load_byte(input logic [24:0] a);
		dl.addr = a;
		dl.data = 8'($urandom);
		dl.wr = 1'b1;
		#5;
		if (load_ok(dl))
			check_req("mem_req", mem_req, expect_load(dl, m_page, m_model));
		else
			check_bit("mem_req.we", mem_req.we, 1'b0);
		tick();
		dl.wr = 1'b0;
		tick();
	endtask

	function automatic logic [7:0] rand_char;
		int r;
		r = $urandom % 20;
		if (r < 10) return 8'("0" + r);
		if (r < 16) return 8'("A" + r - 10);
		return (r < 18) ? "G" : "x";    // Malformed
	endfunction

	//////////////////////////////////////////////////////////////////////
	initial begin
		logic [7:0] ports [5];
		logic [13:0] sh;
		void'($urandom(48));
		ports = '{PORT_GA, PORT_CRTC_SEL, PORT_CRTC_DATA, PORT_PPI, PORT_ROM_SEL};
		reset = 1'b1;
		dl = '0;
		cpu = '0;
		key_nmi = 1'b0;
		cfg_cpc664 = 1'($urandom);
		cfg_mf2 = MF2_ENABLED;
		{m_nmi, m_en, m_hidden, m_old_key, m_old_m1, m_old_io, m_old_wr, m_old_dl} = '0;
		apply_reset(RESET_CYCLES);
		check_bit("model", model, m_model);

		// Standard ROM images with chunks 8 and 9 past the end
		dl.index = DL_IDX_ROM;
		dl.download = 1'b1;
		repeat (ROM_BYTES) load_byte({11'($urandom % 10), 14'($urandom)});
		dl.download = 1'b0;
		tick();
		check_map("rom_map", rom_map, m_map);

		// Expansion images with random extensions
		dl.index = DL_IDX_EXT;
		repeat (EXT_FILES) begin
			dl.ext = {rand_char(), rand_char()};
			dl.download = 1'b1;
			tick();
			repeat (EXT_BYTES) load_byte({3'($urandom), 8'($urandom % 4), 14'($urandom)});
			dl.download = 1'b0;
			tick();
		end

		// Z0 combination moving on to the end page
		dl.ext = "Z0";
		dl.download = 1'b1;
		tick();
		load_byte(25'h0003FFF);
		load_byte(25'h0000000);
		load_byte(25'h0000123);
		dl.download = 1'b0;
		tick();
		check_map("rom_map", rom_map, m_map);

		//////////////////////////////////////////////////////////////////
		// Cartridge control per mode
		for (int m = 0; m < 3; m++) begin
			cfg_mf2 = mf2_mode_t'(m);
			apply_reset(3);
			repeat (CTRL_STEPS) begin
				case ($urandom % 6)
					0, 1: begin
						key_nmi = 1'b1;
						tick();
						key_nmi = 1'b0;
						tick();
					end
					2: fetch(MF2_NMI_VECTOR);
					3: fetch(MF2_HIDE_ADDR);
					4: io_write(16'hFEE8, 8'($urandom));
					default: io_write(16'hFEEA, 8'($urandom));
				endcase
				check_bit("nmi", nmi, m_nmi);
				check_bit("mf2_active", mf2_active, m_en);
			end
		end

		// Shadowed port writes with the fixed ones first
		cfg_mf2 = MF2_ENABLED;
		apply_reset(2);
		io_write({PORT_GA, 8'h00}, 8'h03);
		io_write({PORT_GA, 8'h00}, 8'h40 | 8'($urandom % 32));
		io_write({PORT_GA, 8'h00}, 8'h10);
		io_write({PORT_GA, 8'h00}, 8'h40 | 8'($urandom % 32));
		io_write({PORT_GA, 8'h00}, 8'h80 | 8'($urandom % 64));
		io_write({PORT_GA, 8'h00}, 8'hC0 | 8'($urandom % 64));
		io_write({PORT_CRTC_SEL, 8'h00}, 8'h05);
		io_write({PORT_CRTC_DATA, 8'h00}, 8'($urandom));
		io_write({PORT_PPI, 8'h00}, 8'($urandom));
		io_write({PORT_ROM_SEL, 8'h00}, 8'($urandom));
		repeat (SHADOW_WRITES) begin
			cpu.addr = {ports[$urandom % 5], 8'($urandom)};
			cpu.dout = 8'($urandom);
			sh = shadow_of(cpu.addr[15:8], cpu.dout);
			shadow_q.push_back(sh[12:0]);
			io_write(cpu.addr, cpu.dout);
		end
		io_write(16'hFEE8, 8'h00);
		check_bit("mf2_active", mf2_active, m_en);
		shadow_q.push_back(SHADOW_PEN);
		shadow_q.push_back(SHADOW_BORDER);
		shadow_q.push_back(SHADOW_MODE);
		shadow_q.push_back(SHADOW_BANK);
		shadow_q.push_back(SHADOW_CRTC_SEL);
		shadow_q.push_back(SHADOW_PPI);
		shadow_q.push_back(SHADOW_ROM_SEL);
		shadow_q.push_back({SHADOW_PEN_BASE, 4'h3});
		shadow_q.push_back({SHADOW_CRTC_BASE, 4'h5});

		// Read back through the cartridge RAM window
		cpu.mem_rd = 1'b1;
		foreach (shadow_q[i]) begin
			cpu.addr = {3'b001, shadow_q[i]};
			cpu.ram_a = {10'h0, shadow_q[i]};
			repeat (3) tick();
			check_byte("mf2_dout", mf2_dout, m_ram[shadow_q[i]]);
		end
		cpu.mem_rd = 1'b0;

		//////////////////////////////////////////////////////////////////
		// CPU traffic with the cartridge paged out halfway
		for (int i = 0; i < CPU_STEPS; i++) begin
			if (i == CPU_STEPS / 2) io_write(16'hFEEA, 8'h00);
			cpu.addr = 16'($urandom);
			cpu.ram_a = 23'($urandom);
			cpu.dout = 8'($urandom);
			cpu.mem_rd = 1'($urandom);
			cpu.mem_wr = 1'($urandom);
			#5;
			check_req("mem_req", mem_req, expect_cpu(cpu, m_en, m_model));
			tick();
		end

		$display("Errors: mem_req %0d, rom_map %0d, byte %0d, bit %0d, assertions %0d",
			err_req, err_map, err_byte, err_bit,
			cpc_support_inst.cpc_support_assert_inst.fail_count);
		if (err_req + err_map + err_byte + err_bit
			+ cpc_support_inst.cpc_support_assert_inst.fail_count == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- bench/cpc_support_assert.sv
// Concurrent assertions on the MF2 cartridge and the memory request with their bind
`timescale 1ns/100ps
`default_nettype none

module cpc_support_assert import cpc_support_pkg::*; (
	input wire            clk_sys,
	input wire            reset,
	input wire cpu_bus_t  cpu,
	input wire mem_req_t  mem_req,
	input wire            loading,
	input wire            mf2_en,
	input wire            nmi,
	input wire            mf2_active,
	input wire mf2_mode_t cfg_mf2
);

	int fail_count = 0;

	// No CPU write reaches memory inside 0000-3FFF while paged in
	window_write_masked: assert property (@(posedge clk_sys) disable iff (reset)
		(mf2_en && !loading && cpu.addr[15:14] == 2'b00) |-> !mem_req.we)
		else begin
			fail_count++;
			$error("memory write inside the cartridge window");
		end

	// The vector fetch that clears nmi leaves the cartridge paged in
	nmi_fall_cause: assert property (@(posedge clk_sys) disable iff (reset)
		$fell(nmi) |-> ($past(reset) || mf2_active))
		else begin
			fail_count++;
			$error("nmi dropped without reset or cartridge page-in");
		end

	disabled_stays_off: assert property (@(posedge clk_sys) disable iff (reset)
		(cfg_mf2 == MF2_DISABLED) |-> !$rose(mf2_active))
		else begin
			fail_count++;
			$error("cartridge paged in while disabled");
		end

endmodule

bind cpc_support cpc_support_assert cpc_support_assert_inst (
	.clk_sys    (clk_sys),
	.reset      (reset),
	.cpu        (cpu),
	.mem_req    (mem_req),
	.loading    (loading),
	.mf2_en     (mf2_en),
	.nmi        (nmi),
	.mf2_active (mf2_active),
	.cfg_mf2    (cfg_mf2)
);

`default_nettype wire

//--- source/cpc_support.sv
// Top of the CPC support logic, loader, request mux and MF2 cartridge
`timescale 1ns/100ps
`default_nettype none

module cpc_support import cpc_support_pkg::*; (
	input  wire            clk_sys,
	input  wire            reset,
	input  wire dl_bus_t   dl,
	input  wire cpu_bus_t  cpu,
	input  wire            key_nmi,
	input  wire            cfg_cpc664,
	input  wire mf2_mode_t cfg_mf2,
	output mem_req_t       mem_req,
	output logic [255:0]   rom_map,
	output logic           model,
	output logic [7:0]     mf2_dout,
	output logic           nmi,
	output logic           mf2_active
);

	boot_req_t   boot_req;
	logic        loading;
	logic        mf2_en;
	logic        store;
	logic [12:0] store_addr;

	//////////////////////////////////////////////////////////////////////
	// ROM loading and memory requests
	boot_loader boot_loader_inst (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.dl         (dl),
		.cfg_cpc664 (cfg_cpc664),
		.boot_req   (boot_req),
		.loading    (loading),
		.model      (model),
		.rom_map    (rom_map)
	);

	sdram_request_mux sdram_request_mux_inst (
		.loading  (loading),
		.boot_req (boot_req),
		.cpu      (cpu),
		.model    (model),
		.mf2_en   (mf2_en),
		.mem_req  (mem_req)
	);

	//////////////////////////////////////////////////////////////////////
	// Multiface Two
	mf2_control mf2_control_inst (
		.clk_sys (clk_sys),
		.reset   (reset),
		.cpu     (cpu),
		.key_nmi (key_nmi),
		.cfg_mf2 (cfg_mf2),
		.nmi     (nmi),
		.en      (mf2_en),
		.active  (mf2_active)
	);

	mf2_shadow_map mf2_shadow_map_inst (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.cpu        (cpu),
		.store      (store),
		.store_addr (store_addr)
	);

	mf2_ram mf2_ram_inst (
		.clk_sys    (clk_sys),
		.cpu        (cpu),
		.en         (mf2_en),
		.store      (store),
		.store_addr (store_addr),
		.dout       (mf2_dout)
	);

endmodule

`default_nettype wire

//--- source/mf2_ram.sv
// MF2 8 KB RAM with write address select and gated read data
`timescale 1ns/100ps
`default_nettype none

module mf2_ram import cpc_support_pkg::*; (
	input  wire           clk_sys,
	input  wire cpu_bus_t cpu,
	input  wire           en,
	input  wire           store,
	input  wire [12:0]    store_addr,
	output logic [7:0]    dout
);

	logic [7:0]  ram [8192];
	logic [12:0] ram_a;
	logic        ram_we;
	logic [7:0]  ram_in;
	logic [7:0]  ram_out;
	logic        ram_win;

	assign ram_win = en & (cpu.addr[15:13] == MF2_RAM_WIN);

	// Shadow store beats a CPU write
	always_ff @(posedge clk_sys) begin
		if (store) begin
			ram_a  <= store_addr;
			ram_in <= cpu.dout;
			ram_we <= 1'b1;
		end else if (cpu.mem_wr & ram_win) begin
			ram_a  <= cpu.ram_a[12:0];
			ram_in <= cpu.dout;
			ram_we <= 1'b1;
		end else begin
			ram_a  <= cpu.ram_a[12:0];   // Read slot
			ram_we <= 1'b0;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (ram_we) begin
			ram[ram_a] <= ram_in;
			ram_out    <= ram_in;      // Write-through
		end else begin
			ram_out <= ram[ram_a];
		end
	end

	assign dout = (ram_win & cpu.mem_rd) ? ram_out : 8'hFF;

endmodule

`default_nettype wire

//--- source/mf2_shadow_map.sv
// I/O write decoder to MF2 shadow addresses with pen and CRTC index latches
`timescale 1ns/100ps
`default_nettype none

module mf2_shadow_map import cpc_support_pkg::*; (
	input  wire           clk_sys,
	input  wire           reset,
	input  wire cpu_bus_t cpu,
	output logic          store,
	output logic [12:0]   store_addr
);

	logic       old_io_wr;
	logic [4:0] pen_index;    // Bit 4 selects border
	logic [3:0] crtc_index;
	logic [7:0] port_hi;

	assign port_hi = cpu.addr[15:8];

	always_comb begin
		case (port_hi)
			PORT_GA: begin
				case (cpu.dout[7:6])  // Gate array function
					2'b00: store_addr = SHADOW_PEN;
					2'b01: store_addr = pen_index[4] ? SHADOW_BORDER :
						{SHADOW_PEN_BASE, pen_index[3:0]};
					2'b10: store_addr = SHADOW_MODE;
					default: store_addr = SHADOW_BANK;
				endcase
			end
			PORT_CRTC_SEL:  store_addr = SHADOW_CRTC_SEL;
			PORT_CRTC_DATA: store_addr = {SHADOW_CRTC_BASE, crtc_index};
			PORT_PPI:       store_addr = SHADOW_PPI;
			PORT_ROM_SEL:   store_addr = SHADOW_ROM_SEL;
			default:        store_addr = '0;  // Not shadowed
		endcase
	end

	// One pulse per port write
	assign store = cpu.io_wr & ~old_io_wr & (|store_addr);

	always_ff @(posedge clk_sys) begin
		old_io_wr <= cpu.io_wr;
	end

	//////////////////////////////////////////////////////////////////////
	// Index latches for the indirect slots
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pen_index  <= '0;
			crtc_index <= '0;
		end else if (store) begin
			if (port_hi == PORT_GA && cpu.dout[7:6] == 2'b00)
				pen_index <= cpu.dout[4:0];
			if (port_hi == PORT_CRTC_SEL)
				crtc_index <= cpu.dout[3:0];
		end
	end

endmodule

`default_nettype wire

//--- source/mf2_control.sv
// Multiface Two NMI request, enable and hide state machine
`timescale 1ns/100ps
`default_nettype none

module mf2_control import cpc_support_pkg::*; (
	input  wire            clk_sys,
	input  wire            reset,
	input  wire cpu_bus_t  cpu,
	input  wire            key_nmi,
	input  wire mf2_mode_t cfg_mf2,
	output logic           nmi,
	output logic           en,
	output logic           active
);

	logic old_key_nmi;
	logic old_m1;
	logic old_io_wr;
	logic hidden;
	logic key_rise;
	logic m1_rise;
	logic io_wr_rise;
	logic page_port;
	logic usable;

	assign key_rise   = key_nmi & ~old_key_nmi;
	assign m1_rise    = cpu.m1 & ~old_m1;
	assign io_wr_rise = cpu.io_wr & ~old_io_wr;
	assign page_port  = (cpu.addr[15:2] == MF2_PAGE_PORT);
	assign usable     = (cfg_mf2 != MF2_DISABLED);

	assign active = en;

	always_ff @(posedge clk_sys) begin
		old_key_nmi <= key_nmi;
		old_m1      <= cpu.m1;
		old_io_wr   <= cpu.io_wr;
	end

	//////////////////////////////////////////////////////////////////////
	// Later lines win when two events meet
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			nmi    <= 1'b0;
			en     <= 1'b0;
			hidden <= (cfg_mf2 != MF2_ENABLED);
		end else begin
			if (key_rise & ~en & usable) nmi <= 1'b1;  // Stop button

			// CPU took the NMI, page the cartridge in
			if (nmi & m1_rise & (cpu.addr == MF2_NMI_VECTOR)) begin
				nmi    <= 1'b0;
				en     <= 1'b1;
				hidden <= 1'b0;
			end

			if (en & m1_rise & (cpu.addr == MF2_HIDE_ADDR))
				hidden <= 1'b1;

			// FEE8 pages in, FEEA pages out
			if (io_wr_rise & page_port)
				en <= ~cpu.addr[1] & ~hidden & usable;
		end
	end

endmodule

`default_nettype wire

//--- source/sdram_request_mux.sv
// Memory request select between loader and CPU with the MF2 overlay
`timescale 1ns/100ps
`default_nettype none

module sdram_request_mux import cpc_support_pkg::*; (
	input  wire            loading,
	input  wire boot_req_t boot_req,
	input  wire cpu_bus_t  cpu,
	input  wire            model,
	input  wire            mf2_en,
	output mem_req_t       mem_req
);

	logic rom_win;
	logic ram_win;

	assign rom_win = mf2_en & (cpu.addr[15:13] == MF2_ROM_WIN);
	assign ram_win = mf2_en & (cpu.addr[15:13] == MF2_RAM_WIN);

	always_comb begin
		if (loading) begin
			mem_req.oe   = 1'b0;           // Loader only writes
			mem_req.we   = boot_req.we;
			mem_req.addr = boot_req.addr;
			mem_req.bank = boot_req.bank;
			mem_req.din  = boot_req.din;
		end else begin
			mem_req.oe   = cpu.mem_rd & ~ram_win;            // Cartridge RAM answers
			mem_req.we   = cpu.mem_wr & ~ram_win & ~rom_win;
			mem_req.bank = {1'b0, model};
			mem_req.din  = cpu.dout;

			// Cartridge ROM sits in its own page
			if (rom_win) begin
				{mem_req.addr.rom.hi, mem_req.addr.rom.page} = PAGE_MF2;
				mem_req.addr.rom.offset = cpu.addr[13:0];
			end else begin
				mem_req.addr.flat = cpu.ram_a;
			end
		end
	end

endmodule

`default_nettype wire

//--- source/boot_loader.sv
// ROM download decoder with expansion page select, ROM map and model latch
`timescale 1ns/100ps
`default_nettype none

module boot_loader import cpc_support_pkg::*; (
	input  wire          clk_sys,
	input  wire          reset,
	input  wire dl_bus_t dl,
	input  wire          cfg_cpc664,
	output boot_req_t    boot_req,
	output logic         loading,
	output logic         model,
	output logic [255:0] rom_map
);

	logic        rom_dl;
	logic        ext_dl;
	logic        old_wr;
	logic        old_download;
	logic        wr_fall;
	logic        dl_rise;
	logic        combo;      // "Z0" load, second chunk moves on
	logic        chunk_ok;
	logic [10:0] chunk;
	logic [7:0]  ext_hi;
	logic [7:0]  ext_lo;
	logic [8:0]  page;
	logic [8:0]  ext_page;

	assign rom_dl  = dl.download & (dl.index == DL_IDX_ROM);
	assign ext_dl  = dl.download & (dl.index == DL_IDX_EXT);
	assign loading = reset | rom_dl | ext_dl;
	assign chunk   = dl.addr[24:14];
	assign ext_hi  = dl.ext[15:8];
	assign ext_lo  = dl.ext[7:0];
	assign wr_fall = (rom_dl | ext_dl) & old_wr & ~dl.wr;
	assign dl_rise = ext_dl & ~old_download & dl.download;

	// Hex characters to page, anything else keeps the bad page bits
	always_comb begin
		ext_page = PAGE_BAD_EXT;
		if (ext_hi >= "0" && ext_hi <= "9") ext_page[7:4] = ext_hi[3:0];
		else if (ext_hi >= "A" && ext_hi <= "F") ext_page[7:4] = ext_hi[3:0] + 4'd9;
		if (ext_lo >= "0" && ext_lo <= "9") ext_page[3:0] = ext_lo[3:0];
		else if (ext_lo >= "A" && ext_lo <= "F") ext_page[3:0] = ext_lo[3:0] + 4'd9;
		if (dl.ext == "ZZ" || dl.ext == "Z0") ext_page = '0;
	end

	//////////////////////////////////////////////////////////////////////
	// Write request
	always_comb begin
		boot_req.din             = dl.data;
		boot_req.bank            = '0;
		boot_req.addr.flat       = '1;
		boot_req.addr.rom.offset = dl.addr[13:0];
		chunk_ok                 = 1'b1;

		if (ext_dl) begin
			boot_req.addr.rom.hi   = page[8];
			boot_req.addr.rom.page = page[7:0] + dl.addr[21:14];
			boot_req.bank          = {1'b0, model};
		end else begin
			case (chunk)
				11'd0, 11'd4: {boot_req.addr.rom.hi, boot_req.addr.rom.page} = PAGE_OS;
				11'd1, 11'd5: {boot_req.addr.rom.hi, boot_req.addr.rom.page} = PAGE_BASIC;
				11'd2, 11'd6: {boot_req.addr.rom.hi, boot_req.addr.rom.page} = PAGE_AMSDOS;
				11'd3, 11'd7: {boot_req.addr.rom.hi, boot_req.addr.rom.page} = PAGE_MF2;
				default: chunk_ok = 1'b0;                 // Past the last image
			endcase
			boot_req.bank = {1'b0, chunk_ok & chunk[2]};  // 664 set in bank 1
		end

		boot_req.we = (rom_dl | ext_dl) & dl.wr & chunk_ok;
	end

	//////////////////////////////////////////////////////////////////////
	// Page register, combination and ROM map
	always_ff @(posedge clk_sys) begin
		old_wr       <= dl.wr;
		old_download <= dl.download;

		if (reset) begin
			page    <= '0;
			combo   <= 1'b0;
			rom_map <= '0;
		end else begin
			if (wr_fall & chunk_ok) begin
				if (boot_req.addr.rom.hi) rom_map[boot_req.addr.rom.page] <= 1'b1;
				if (combo && &boot_req.addr.rom.offset) begin // End of first 16 KB
					combo <= 1'b0;
					page  <= PAGE_COMBO_END;
				end
			end
			if (dl_rise) begin
				page  <= ext_page;
				combo <= (dl.ext == "Z0");
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) model <= cfg_cpc664;
	end

endmodule

`default_nettype wire

//--- source/cpc_support_pkg.sv
// Download indexes, fixed ROM pages, MF2 addresses and ports, mode enum, bus structs, address union
`default_nettype none

package cpc_support_pkg;

	//////////////////////////////////////////////////////////////////////
	// Download stream
	localparam logic [7:0] DL_IDX_ROM = 8'd0;  // Standard ROM image
	localparam logic [7:0] DL_IDX_EXT = 8'd3;  // Expansion ROM, page from extension

	// Fixed 9-bit pages, bit 8 is the high-ROM half
	localparam logic [8:0] PAGE_OS        = 9'h000;
	localparam logic [8:0] PAGE_BASIC     = 9'h100;
	localparam logic [8:0] PAGE_AMSDOS    = 9'h107;
	localparam logic [8:0] PAGE_MF2       = 9'h0FF;
	localparam logic [8:0] PAGE_BAD_EXT   = 9'h1EE; // Unused page for broken names
	localparam logic [8:0] PAGE_COMBO_END = 9'h1FF;

	//////////////////////////////////////////////////////////////////////
	// Multiface Two
	localparam logic [15:0] MF2_NMI_VECTOR = 16'h0066;
	localparam logic [15:0] MF2_HIDE_ADDR  = 16'h0065;
	localparam logic [13:0] MF2_PAGE_PORT  = 14'b11111110111010; // FEE8 / FEEA
	localparam logic [2:0]  MF2_ROM_WIN    = 3'b000;             // 0000-1FFF
	localparam logic [2:0]  MF2_RAM_WIN    = 3'b001;             // 2000-3FFF

	// Upper port bytes that get shadowed
	localparam logic [7:0] PORT_GA        = 8'h7F;
	localparam logic [7:0] PORT_CRTC_SEL  = 8'hBC;
	localparam logic [7:0] PORT_CRTC_DATA = 8'hBD;
	localparam logic [7:0] PORT_PPI       = 8'hF7;
	localparam logic [7:0] PORT_ROM_SEL   = 8'hDF;

	// Shadow copies inside the 8 KB RAM
	localparam logic [12:0] SHADOW_PEN       = 13'h1FCF;
	localparam logic [12:0] SHADOW_BORDER    = 13'h1FDF;
	localparam logic [12:0] SHADOW_MODE      = 13'h1FEF;
	localparam logic [12:0] SHADOW_BANK      = 13'h1FFF;
	localparam logic [12:0] SHADOW_CRTC_SEL  = 13'h1CFF;
	localparam logic [12:0] SHADOW_PPI       = 13'h17FF;
	localparam logic [12:0] SHADOW_ROM_SEL   = 13'h1AAC;
	localparam logic [8:0]  SHADOW_PEN_BASE  = 9'h1F9;  // + pen number
	localparam logic [8:0]  SHADOW_CRTC_BASE = 9'h1DB;  // + CRTC register

	typedef enum logic [1:0] {
		MF2_ENABLED  = 2'd0,
		MF2_HIDDEN   = 2'd1,
		MF2_DISABLED = 2'd2
	} mf2_mode_t;

	//////////////////////////////////////////////////////////////////////
	// Memory address, flat or as ROM page
	typedef struct packed {
		logic        hi;      // Second 4 MB, high ROMs
		logic [7:0]  page;
		logic [13:0] offset;
	} rom_loc_t;

	typedef union packed {
		logic [22:0] flat;
		rom_loc_t    rom;
	} mem_addr_u;

	typedef struct packed {
		logic        wr;
		logic [24:0] addr;
		logic [7:0]  data;
		logic        download;
		logic [7:0]  index;
		logic [15:0] ext;     // Last two extension characters
	} dl_bus_t;

	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  dout;
		logic        m1;
		logic        mem_rd;
		logic        mem_wr;
		logic        io_wr;
		logic [22:0] ram_a;
	} cpu_bus_t;

	typedef struct packed {
		logic       oe;
		logic       we;
		mem_addr_u  addr;
		logic [1:0] bank;
		logic [7:0] din;
	} mem_req_t;

	typedef struct packed {
		logic       we;
		mem_addr_u  addr;
		logic [1:0] bank;
		logic [7:0] din;
	} boot_req_t;

endpackage

`default_nettype wire
